// ==== source/bwt_ext_params.svh ====
`ifndef BWT_EXT_PARAMS_SVH
`define BWT_EXT_PARAMS_SVH

// ------------------------------------------------------------
// read geometry
// ------------------------------------------------------------
`define BWT_READ_LEN    16      // bases per read
`define BWT_BASE_W      2       // 2-bit base code
`define BWT_READ_NUM_W  8
`define BWT_READ_DEPTH  8       // read buffer entries

// ------------------------------------------------------------
// index geometry
// ------------------------------------------------------------
`define BWT_IDX_W       32
`define BWT_SEQ_LEN     65536   // initial l

// block start of each base in the index
`define BWT_L2_0        0
`define BWT_L2_1        16384
`define BWT_L2_2        32768
`define BWT_L2_3        49152

`endif

// ==== source/bwt_ext_pkg.sv ====
`include "bwt_ext_params.svh"

package bwt_ext_pkg;

	// base codes, complement is the bitwise inverse
	typedef enum logic [`BWT_BASE_W-1:0] {
		BASE_A = 2'd0,
		BASE_C = 2'd1,
		BASE_G = 2'd2,
		BASE_T = 2'd3
	} base_t;

	typedef enum logic [1:0] {
		EXT_IDLE,
		EXT_REQ,   // request on the memory port
		EXT_WAIT,  // waiting for occurrence counts
		EXT_DONE   // result held until acknowledged
	} ext_state_t;

	typedef logic [`BWT_IDX_W-1:0]      bwt_idx_t;
	typedef logic [`BWT_READ_NUM_W-1:0] read_num_t;
	typedef logic [4:0]                 match_len_t;  // 0 to 16

	// one count per base, index with base_t
	typedef bwt_idx_t [3:0] occ_vec_t;

	// base 0 in the low bits
	typedef base_t [`BWT_READ_LEN-1:0] read_seq_t;

endpackage

// ==== source/read_buffer.sv ====
`include "bwt_ext_params.svh"

module read_buffer (
	input  logic                   Clk_32UI,
	input  logic                   rst_n_i,
	// load side
	input  logic                   load_valid_i,
	output logic                   load_ready_o,
	input  bwt_ext_pkg::read_seq_t load_seq_i,
	// engine side
	output logic                   rd_valid_o,
	input  logic                   rd_fwd_ready_i,
	input  logic                   rd_bwd_ready_i,
	output bwt_ext_pkg::read_seq_t rd_seq_o,
	output bwt_ext_pkg::read_num_t rd_num_o
);

	localparam int PTR_W = $clog2(`BWT_READ_DEPTH);
	localparam int CNT_W = $clog2(`BWT_READ_DEPTH + 1);

	bwt_ext_pkg::read_seq_t seq_mem [`BWT_READ_DEPTH];
	bwt_ext_pkg::read_num_t num_mem [`BWT_READ_DEPTH];

	logic [PTR_W-1:0]       wr_ptr_q;
	logic [PTR_W-1:0]       rd_ptr_q;
	logic [CNT_W-1:0]       count_q;
	bwt_ext_pkg::read_num_t next_num_q;  // stamp for the next loaded read
	logic                   push;
	logic                   pop;

	assign load_ready_o = (count_q != CNT_W'(`BWT_READ_DEPTH));
	assign rd_valid_o   = (count_q != '0);

	assign push = load_valid_i & load_ready_o;
	// both engines take the same read together
	assign pop  = rd_valid_o & rd_fwd_ready_i & rd_bwd_ready_i;

	assign rd_seq_o = seq_mem[rd_ptr_q];
	assign rd_num_o = num_mem[rd_ptr_q];

	// storage
	always_ff @(posedge Clk_32UI) begin
		if (push) begin
			seq_mem[wr_ptr_q] <= load_seq_i;
			num_mem[wr_ptr_q] <= next_num_q;
		end
	end

	// ------------------------------------------------------------
	// pointers and occupancy
	// ------------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!rst_n_i) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			count_q    <= '0;
			next_num_q <= '0;
		end else begin
			if (push) begin
				wr_ptr_q   <= wr_ptr_q + 1'b1;  // depth is a power of two
				next_num_q <= next_num_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

// ==== source/extension_engine.sv ====
`include "bwt_ext_params.svh"

module extension_engine #(
	parameter bit BACKWARD = 1'b0  // walk from the last base, complemented
) (
	input  logic                    Clk_32UI,
	input  logic                    rst_n_i,
	// read in
	input  logic                    rd_valid_i,
	output logic                    rd_ready_o,
	input  bwt_ext_pkg::read_seq_t  rd_seq_i,
	// occurrence request
	output logic                    req_valid_o,
	input  logic                    req_ready_i,
	output bwt_ext_pkg::bwt_idx_t   addr_k_o,
	output bwt_ext_pkg::bwt_idx_t   addr_l_o,
	// occurrence response
	input  logic                    rsp_valid_i,
	input  bwt_ext_pkg::occ_vec_t   cnt_k_i,
	input  bwt_ext_pkg::occ_vec_t   cnt_l_i,
	// result
	output logic                    res_valid_o,
	input  logic                    res_ack_i,
	output bwt_ext_pkg::match_len_t res_len_o,
	output bwt_ext_pkg::bwt_idx_t   res_k_o,
	output bwt_ext_pkg::bwt_idx_t   res_l_o
);

	bwt_ext_pkg::ext_state_t state_q;
	bwt_ext_pkg::read_seq_t  seq_q;
	bwt_ext_pkg::bwt_idx_t   k_q;
	bwt_ext_pkg::bwt_idx_t   l_q;
	bwt_ext_pkg::match_len_t len_q;   // bases matched so far

	logic [3:0]              pos;
	bwt_ext_pkg::base_t      raw_base;
	bwt_ext_pkg::base_t      cur_base;
	bwt_ext_pkg::bwt_idx_t   l2_start;
	bwt_ext_pkg::bwt_idx_t   new_k;
	bwt_ext_pkg::bwt_idx_t   new_l;
	logic                    hit;
	logic                    last_base;

	// ------------------------------------------------------------
	// base selection
	// ------------------------------------------------------------
	// len_q doubles as the position, a miss ends the read
	assign pos      = BACKWARD ? (4'(`BWT_READ_LEN - 1) - len_q[3:0]) : len_q[3:0];
	assign raw_base = seq_q[pos];
	assign cur_base = BACKWARD ? bwt_ext_pkg::base_t'(~raw_base) : raw_base;  // A<->T, C<->G

	always_comb begin
		case (cur_base)
			bwt_ext_pkg::BASE_A: l2_start = `BWT_L2_0;
			bwt_ext_pkg::BASE_C: l2_start = `BWT_L2_1;
			bwt_ext_pkg::BASE_G: l2_start = `BWT_L2_2;
			default:             l2_start = `BWT_L2_3;
		endcase
	end

	assign new_k     = l2_start + cnt_k_i[cur_base];
	assign new_l     = l2_start + cnt_l_i[cur_base];
	assign hit       = (new_k < new_l);  // interval still non-empty
	assign last_base = (len_q == bwt_ext_pkg::match_len_t'(`BWT_READ_LEN - 1));

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!rst_n_i) begin
			state_q <= bwt_ext_pkg::EXT_IDLE;
		end else begin
			case (state_q)
				bwt_ext_pkg::EXT_IDLE: begin
					if (rd_valid_i)
						state_q <= bwt_ext_pkg::EXT_REQ;
				end
				bwt_ext_pkg::EXT_REQ: begin
					if (req_ready_i)
						state_q <= bwt_ext_pkg::EXT_WAIT;
				end
				bwt_ext_pkg::EXT_WAIT: begin
					if (rsp_valid_i) begin
						if (hit && !last_base)
							state_q <= bwt_ext_pkg::EXT_REQ;
						else
							state_q <= bwt_ext_pkg::EXT_DONE;
					end
				end
				default: begin  // EXT_DONE
					if (res_ack_i)
						state_q <= bwt_ext_pkg::EXT_IDLE;
				end
			endcase
		end
	end

	// interval and length
	always_ff @(posedge Clk_32UI) begin
		if (state_q == bwt_ext_pkg::EXT_IDLE && rd_valid_i) begin
			seq_q <= rd_seq_i;
			k_q   <= '0;
			l_q   <= `BWT_SEQ_LEN;
			len_q <= '0;
		end else if (state_q == bwt_ext_pkg::EXT_WAIT && rsp_valid_i && hit) begin
			k_q   <= new_k;
			l_q   <= new_l;
			len_q <= len_q + 5'd1;
		end
	end

	assign rd_ready_o  = (state_q == bwt_ext_pkg::EXT_IDLE);
	assign req_valid_o = (state_q == bwt_ext_pkg::EXT_REQ);
	assign addr_k_o    = k_q;  // steady while waiting for the port
	assign addr_l_o    = l_q;
	assign res_valid_o = (state_q == bwt_ext_pkg::EXT_DONE);
	assign res_len_o   = len_q;
	assign res_k_o     = k_q;
	assign res_l_o     = l_q;

endmodule

// ==== source/extension_join.sv ====
module extension_join (
	input  logic                    Clk_32UI,
	input  logic                    rst_n_i,
	// engine requests
	input  logic                    fwd_req_valid_i,
	output logic                    fwd_req_ready_o,
	input  bwt_ext_pkg::bwt_idx_t   fwd_addr_k_i,
	input  bwt_ext_pkg::bwt_idx_t   fwd_addr_l_i,
	input  logic                    bwd_req_valid_i,
	output logic                    bwd_req_ready_o,
	input  bwt_ext_pkg::bwt_idx_t   bwd_addr_k_i,
	input  bwt_ext_pkg::bwt_idx_t   bwd_addr_l_i,
	// memory port
	output logic                    mem_req_valid_o,
	input  logic                    mem_req_ready_i,
	output bwt_ext_pkg::bwt_idx_t   mem_addr_k_o,
	output bwt_ext_pkg::bwt_idx_t   mem_addr_l_o,
	input  logic                    mem_rsp_valid_i,
	output logic                    fwd_rsp_valid_o,
	output logic                    bwd_rsp_valid_o,
	// engine results
	input  logic                    fwd_res_valid_i,
	input  bwt_ext_pkg::match_len_t fwd_res_len_i,
	input  bwt_ext_pkg::bwt_idx_t   fwd_res_k_i,
	input  bwt_ext_pkg::bwt_idx_t   fwd_res_l_i,
	input  logic                    bwd_res_valid_i,
	input  bwt_ext_pkg::match_len_t bwd_res_len_i,
	input  bwt_ext_pkg::bwt_idx_t   bwd_res_k_i,
	input  bwt_ext_pkg::bwt_idx_t   bwd_res_l_i,
	input  bwt_ext_pkg::read_num_t  rd_num_i,
	output logic                    res_ack_o,
	// joined output
	output logic                    out_valid_o,
	input  logic                    out_ready_i,
	output bwt_ext_pkg::read_num_t  out_read_num_o,
	output bwt_ext_pkg::match_len_t out_fwd_len_o,
	output bwt_ext_pkg::bwt_idx_t   out_fwd_k_o,
	output bwt_ext_pkg::bwt_idx_t   out_fwd_l_o,
	output bwt_ext_pkg::match_len_t out_bwd_len_o,
	output bwt_ext_pkg::bwt_idx_t   out_bwd_k_o,
	output bwt_ext_pkg::bwt_idx_t   out_bwd_l_o
);

	logic                   hold_bwd_q;  // bwd owns a stalled port
	logic                   sel_bwd;
	logic                   req_fire;
	logic                   tag_mem [2];  // 1 = backward owner
	logic                   tag_wr_q;
	logic                   tag_rd_q;
	logic                   eng_idle_q;
	bwt_ext_pkg::read_num_t read_num_q;

	// ------------------------------------------------------------
	// arbitration, forward wins a tie
	// ------------------------------------------------------------
	assign sel_bwd         = hold_bwd_q | (bwd_req_valid_i & ~fwd_req_valid_i);
	assign mem_req_valid_o = fwd_req_valid_i | bwd_req_valid_i;
	assign mem_addr_k_o    = sel_bwd ? bwd_addr_k_i : fwd_addr_k_i;
	assign mem_addr_l_o    = sel_bwd ? bwd_addr_l_i : fwd_addr_l_i;
	assign fwd_req_ready_o = mem_req_ready_i & ~sel_bwd;
	assign bwd_req_ready_o = mem_req_ready_i & sel_bwd;
	assign req_fire        = mem_req_valid_o & mem_req_ready_i;

	// responses in request order, owner at the tag head
	assign fwd_rsp_valid_o = mem_rsp_valid_i & ~tag_mem[tag_rd_q];
	assign bwd_rsp_valid_o = mem_rsp_valid_i & tag_mem[tag_rd_q];

	always_ff @(posedge Clk_32UI) begin
		if (req_fire)
			tag_mem[tag_wr_q] <= sel_bwd;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!rst_n_i) begin
			hold_bwd_q <= 1'b0;
			tag_wr_q   <= 1'b0;
			tag_rd_q   <= 1'b0;
			eng_idle_q <= 1'b1;
		end else begin
			hold_bwd_q <= sel_bwd & bwd_req_valid_i & ~mem_req_ready_i;
			if (req_fire)
				tag_wr_q <= ~tag_wr_q;
			if (mem_rsp_valid_i)
				tag_rd_q <= ~tag_rd_q;
			// engines idle from ack until their first request
			if (res_ack_o)
				eng_idle_q <= 1'b1;
			else if (fwd_req_valid_i)
				eng_idle_q <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// result join
	// ------------------------------------------------------------
	// last value seen before the first request is the popped read
	always_ff @(posedge Clk_32UI) begin
		if (eng_idle_q && !fwd_req_valid_i)
			read_num_q <= rd_num_i;
	end

	assign res_ack_o = out_valid_o & out_ready_i;

	always_ff @(posedge Clk_32UI) begin
		if (!rst_n_i) begin
			out_valid_o <= 1'b0;
		end else if (res_ack_o) begin
			out_valid_o <= 1'b0;
		end else if (fwd_res_valid_i && bwd_res_valid_i) begin
			out_valid_o <= 1'b1;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!out_valid_o && fwd_res_valid_i && bwd_res_valid_i) begin
			out_read_num_o <= read_num_q;
			out_fwd_len_o  <= fwd_res_len_i;
			out_fwd_k_o    <= fwd_res_k_i;
			out_fwd_l_o    <= fwd_res_l_i;
			out_bwd_len_o  <= bwd_res_len_i;
			out_bwd_k_o    <= bwd_res_k_i;
			out_bwd_l_o    <= bwd_res_l_i;
		end
	end

endmodule

// ==== source/bwt_ext_top.sv ====
module bwt_ext_top (
	input  logic                    Clk_32UI,
	input  logic                    rst_n_i,
	// read loading
	input  logic                    load_valid_i,
	output logic                    load_ready_o,
	input  bwt_ext_pkg::read_seq_t  load_seq_i,
	// occurrence memory
	output logic                    mem_req_valid_o,
	input  logic                    mem_req_ready_i,
	output bwt_ext_pkg::bwt_idx_t   mem_addr_k_o,
	output bwt_ext_pkg::bwt_idx_t   mem_addr_l_o,
	input  logic                    mem_rsp_valid_i,
	input  bwt_ext_pkg::occ_vec_t   mem_cnt_k_i,
	input  bwt_ext_pkg::occ_vec_t   mem_cnt_l_i,
	// joined results
	output logic                    out_valid_o,
	input  logic                    out_ready_i,
	output bwt_ext_pkg::read_num_t  out_read_num_o,
	output bwt_ext_pkg::match_len_t out_fwd_len_o,
	output bwt_ext_pkg::bwt_idx_t   out_fwd_k_o,
	output bwt_ext_pkg::bwt_idx_t   out_fwd_l_o,
	output bwt_ext_pkg::match_len_t out_bwd_len_o,
	output bwt_ext_pkg::bwt_idx_t   out_bwd_k_o,
	output bwt_ext_pkg::bwt_idx_t   out_bwd_l_o
);

	// buffer to engines
	logic                    rd_valid;
	logic                    fwd_rd_ready;
	logic                    bwd_rd_ready;
	bwt_ext_pkg::read_seq_t  rd_seq;
	bwt_ext_pkg::read_num_t  rd_num;

	// engines to join
	logic                    fwd_req_valid, fwd_req_ready, fwd_rsp_valid;
	logic                    bwd_req_valid, bwd_req_ready, bwd_rsp_valid;
	bwt_ext_pkg::bwt_idx_t   fwd_addr_k, fwd_addr_l;
	bwt_ext_pkg::bwt_idx_t   bwd_addr_k, bwd_addr_l;
	logic                    fwd_res_valid, bwd_res_valid;
	bwt_ext_pkg::match_len_t fwd_res_len, bwd_res_len;
	bwt_ext_pkg::bwt_idx_t   fwd_res_k, fwd_res_l;
	bwt_ext_pkg::bwt_idx_t   bwd_res_k, bwd_res_l;
	logic                    res_ack;

	read_buffer i_read_buffer (
		.Clk_32UI       (Clk_32UI),
		.rst_n_i        (rst_n_i),
		.load_valid_i   (load_valid_i),
		.load_ready_o   (load_ready_o),
		.load_seq_i     (load_seq_i),
		.rd_valid_o     (rd_valid),
		.rd_fwd_ready_i (fwd_rd_ready),
		.rd_bwd_ready_i (bwd_rd_ready),
		.rd_seq_o       (rd_seq),
		.rd_num_o       (rd_num)
	);

	// ------------------------------------------------------------
	// engine pair, same read side by side
	// ------------------------------------------------------------
	extension_engine #(.BACKWARD(1'b0)) i_fwd_engine (
		.Clk_32UI    (Clk_32UI),       .rst_n_i     (rst_n_i),
		.rd_valid_i  (rd_valid),       .rd_ready_o  (fwd_rd_ready),  .rd_seq_i (rd_seq),
		.req_valid_o (fwd_req_valid),  .req_ready_i (fwd_req_ready),
		.addr_k_o    (fwd_addr_k),     .addr_l_o    (fwd_addr_l),
		.rsp_valid_i (fwd_rsp_valid),  .cnt_k_i     (mem_cnt_k_i),   .cnt_l_i  (mem_cnt_l_i),
		.res_valid_o (fwd_res_valid),  .res_ack_i   (res_ack),
		.res_len_o   (fwd_res_len),    .res_k_o     (fwd_res_k),     .res_l_o  (fwd_res_l)
	);

	extension_engine #(.BACKWARD(1'b1)) i_bwd_engine (
		.Clk_32UI    (Clk_32UI),       .rst_n_i     (rst_n_i),
		.rd_valid_i  (rd_valid),       .rd_ready_o  (bwd_rd_ready),  .rd_seq_i (rd_seq),
		.req_valid_o (bwd_req_valid),  .req_ready_i (bwd_req_ready),
		.addr_k_o    (bwd_addr_k),     .addr_l_o    (bwd_addr_l),
		.rsp_valid_i (bwd_rsp_valid),  .cnt_k_i     (mem_cnt_k_i),   .cnt_l_i  (mem_cnt_l_i),
		.res_valid_o (bwd_res_valid),  .res_ack_i   (res_ack),
		.res_len_o   (bwd_res_len),    .res_k_o     (bwd_res_k),     .res_l_o  (bwd_res_l)
	);

	extension_join i_extension_join (
		.Clk_32UI        (Clk_32UI),        .rst_n_i         (rst_n_i),
		.fwd_req_valid_i (fwd_req_valid),   .fwd_req_ready_o (fwd_req_ready),
		.fwd_addr_k_i    (fwd_addr_k),      .fwd_addr_l_i    (fwd_addr_l),
		.bwd_req_valid_i (bwd_req_valid),   .bwd_req_ready_o (bwd_req_ready),
		.bwd_addr_k_i    (bwd_addr_k),      .bwd_addr_l_i    (bwd_addr_l),
		.mem_req_valid_o (mem_req_valid_o), .mem_req_ready_i (mem_req_ready_i),
		.mem_addr_k_o    (mem_addr_k_o),    .mem_addr_l_o    (mem_addr_l_o),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.fwd_rsp_valid_o (fwd_rsp_valid),   .bwd_rsp_valid_o (bwd_rsp_valid),
		.fwd_res_valid_i (fwd_res_valid),   .fwd_res_len_i   (fwd_res_len),
		.fwd_res_k_i     (fwd_res_k),       .fwd_res_l_i     (fwd_res_l),
		.bwd_res_valid_i (bwd_res_valid),   .bwd_res_len_i   (bwd_res_len),
		.bwd_res_k_i     (bwd_res_k),       .bwd_res_l_i     (bwd_res_l),
		.rd_num_i        (rd_num),          .res_ack_o       (res_ack),
		.out_valid_o     (out_valid_o),     .out_ready_i     (out_ready_i),
		.out_read_num_o  (out_read_num_o),
		.out_fwd_len_o   (out_fwd_len_o),   .out_fwd_k_o     (out_fwd_k_o),
		.out_fwd_l_o     (out_fwd_l_o),
		.out_bwd_len_o   (out_bwd_len_o),   .out_bwd_k_o     (out_bwd_k_o),
		.out_bwd_l_o     (out_bwd_l_o)
	);

endmodule

// ==== tests/bwt_ext_asserts.sv ====
`include "bwt_ext_params.svh"

module bwt_ext_asserts (
	input logic                    clk_i,
	input logic                    rst_n_i,
	input logic                    load_valid_i,
	input logic                    load_ready_i,
	input bwt_ext_pkg::read_seq_t  load_seq_i,
	input logic                    mem_req_valid_i,
	input logic                    mem_req_ready_i,
	input bwt_ext_pkg::bwt_idx_t   mem_addr_k_i,
	input bwt_ext_pkg::bwt_idx_t   mem_addr_l_i,
	input logic                    mem_rsp_valid_i,
	input logic                    out_valid_i,
	input logic                    out_ready_i,
	input bwt_ext_pkg::read_num_t  out_read_num_i,
	input bwt_ext_pkg::match_len_t out_fwd_len_i,
	input bwt_ext_pkg::bwt_idx_t   out_fwd_k_i,
	input bwt_ext_pkg::bwt_idx_t   out_fwd_l_i,
	input bwt_ext_pkg::match_len_t out_bwd_len_i,
	input bwt_ext_pkg::bwt_idx_t   out_bwd_k_i,
	input bwt_ext_pkg::bwt_idx_t   out_bwd_l_i
);

	localparam int RES_W = 5 + 2 * `BWT_IDX_W;  // {len, k, l}

	int                     fail_cnt = 0;
	bwt_ext_pkg::read_seq_t read_q [$];   // accepted reads, oldest first
	bwt_ext_pkg::read_seq_t head_seq;
	bwt_ext_pkg::read_num_t out_cnt;
	int                     req_cnt;
	int                     rsp_cnt;
	logic [RES_W-1:0]       exp_fwd;
	logic [RES_W-1:0]       exp_bwd;
	logic [RES_W-1:0]       act_fwd;
	logic [RES_W-1:0]       act_bwd;
	logic [RES_W*2+7:0]     out_word;
	logic                   out_fire;

	function automatic bwt_ext_pkg::bwt_idx_t block_start(input logic [1:0] b);
		case (b)
			2'd0:    return `BWT_L2_0;
			2'd1:    return `BWT_L2_1;
			2'd2:    return `BWT_L2_2;
			default: return `BWT_L2_3;
		endcase
	endfunction

	// ------------------------------------------------------------
	// reference extension, occurrence count is address / 4
	// ------------------------------------------------------------
	function automatic logic [RES_W-1:0] extend_model(input bwt_ext_pkg::read_seq_t seq,
			input bit backward);
		bwt_ext_pkg::bwt_idx_t k;
		bwt_ext_pkg::bwt_idx_t l;
		bwt_ext_pkg::bwt_idx_t nk;
		bwt_ext_pkg::bwt_idx_t nl;
		logic [1:0]            b;
		int                    len;
		bit                    stop;
		k    = '0;
		l    = `BWT_SEQ_LEN;
		len  = 0;
		stop = 1'b0;
		for (int i = 0; i < `BWT_READ_LEN; i++) begin
			b = backward ? seq[`BWT_READ_LEN - 1 - i] : seq[i];
			if (backward)
				b = 2'd3 - b;  // A<->T, C<->G
			nk = block_start(b) + k / 4;
			nl = block_start(b) + l / 4;
			if (!stop && nk < nl) begin
				k = nk;
				l = nl;
				len++;
			end else begin
				stop = 1'b1;  // empty interval ends the walk
			end
		end
		return {5'(len), k, l};
	endfunction

	assign out_fire = out_valid_i & out_ready_i;
	assign act_fwd  = {out_fwd_len_i, out_fwd_k_i, out_fwd_l_i};
	assign act_bwd  = {out_bwd_len_i, out_bwd_k_i, out_bwd_l_i};
	assign out_word = {out_read_num_i, act_fwd, act_bwd};
	assign exp_fwd  = extend_model(head_seq, 1'b0);
	assign exp_bwd  = extend_model(head_seq, 1'b1);

	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			read_q.delete();
			out_cnt <= '0;
			req_cnt <= 0;
			rsp_cnt <= 0;
		end else begin
			if (out_fire) begin
				void'(read_q.pop_front());
				out_cnt <= out_cnt + 1'b1;
			end
			if (load_valid_i && load_ready_i)
				read_q.push_back(load_seq_i);
			if (mem_req_valid_i && mem_req_ready_i)
				req_cnt <= req_cnt + 1;
			if (mem_rsp_valid_i)
				rsp_cnt <= rsp_cnt + 1;
		end
		if (read_q.size() != 0)
			head_seq <= read_q[0];  // next read to come out
	end

	a_reset_quiet: assert property (@(posedge clk_i)
		$rose(rst_n_i) |-> !out_valid_i && !mem_req_valid_i)
		else begin
			$error("a valid output was high in the first cycle after reset");
			fail_cnt++;
		end

	a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		mem_req_valid_i && !mem_req_ready_i |=>
			mem_req_valid_i && $stable(mem_addr_k_i) && $stable(mem_addr_l_i))
		else begin
			$error("a stalled memory request dropped or changed its addresses");
			fail_cnt++;
		end

	a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_word))
		else begin
			$error("a stalled output dropped or changed");
			fail_cnt++;
		end

	a_read_num: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		out_fire |-> out_read_num_i == out_cnt)
		else begin
			$error("[FAIL] read_num expected %0d actual %0d",
				$sampled(out_cnt), $sampled(out_read_num_i));
			fail_cnt++;
		end

	a_fwd_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		out_fire |-> act_fwd == exp_fwd)
		else begin
			$error("[FAIL] fwd_result expected %h actual %h",
				$sampled(exp_fwd), $sampled(act_fwd));
			fail_cnt++;
		end

	a_bwd_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		out_fire |-> act_bwd == exp_bwd)
		else begin
			$error("[FAIL] bwd_result expected %h actual %h",
				$sampled(exp_bwd), $sampled(act_bwd));
			fail_cnt++;
		end

	// a response needs an accepted request still open
	a_rsp_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		mem_rsp_valid_i |-> rsp_cnt < req_cnt)
		else begin
			$error("[FAIL] rsp_count expected below %0d actual %0d",
				$sampled(req_cnt), $sampled(rsp_cnt));
			fail_cnt++;
		end

endmodule

bind bwt_ext_top bwt_ext_asserts i_asserts (
	.clk_i           (Clk_32UI),
	.rst_n_i         (rst_n_i),
	.load_valid_i    (load_valid_i),
	.load_ready_i    (load_ready_o),
	.load_seq_i      (load_seq_i),
	.mem_req_valid_i (mem_req_valid_o),
	.mem_req_ready_i (mem_req_ready_i),
	.mem_addr_k_i    (mem_addr_k_o),
	.mem_addr_l_i    (mem_addr_l_o),
	.mem_rsp_valid_i (mem_rsp_valid_i),
	.out_valid_i     (out_valid_o),
	.out_ready_i     (out_ready_i),
	.out_read_num_i  (out_read_num_o),
	.out_fwd_len_i   (out_fwd_len_o),
	.out_fwd_k_i     (out_fwd_k_o),
	.out_fwd_l_i     (out_fwd_l_o),
	.out_bwd_len_i   (out_bwd_len_o),
	.out_bwd_k_i     (out_bwd_k_o),
	.out_bwd_l_i     (out_bwd_l_o)
);

// ==== tests/tb_bwt_ext.sv ====
`include "bwt_ext_params.svh"

module tb_bwt_ext;

	localparam int NUM_READS  = 20;
	localparam int WAIT_LIMIT = 3000;  // cycles per wait loop

	logic                    clk;
	logic                    rst_n;
	logic                    load_valid;
	logic                    load_ready;
	bwt_ext_pkg::read_seq_t  load_seq;
	logic                    mem_req_valid;
	logic                    mem_req_ready = 1'b0;
	bwt_ext_pkg::bwt_idx_t   mem_addr_k;
	bwt_ext_pkg::bwt_idx_t   mem_addr_l;
	logic                    mem_rsp_valid = 1'b0;
	bwt_ext_pkg::occ_vec_t   mem_cnt_k = '0;
	bwt_ext_pkg::occ_vec_t   mem_cnt_l = '0;
	logic                    out_valid;
	logic                    out_ready = 1'b0;
	bwt_ext_pkg::read_num_t  out_read_num;
	bwt_ext_pkg::match_len_t out_fwd_len;
	bwt_ext_pkg::bwt_idx_t   out_fwd_k;
	bwt_ext_pkg::bwt_idx_t   out_fwd_l;
	bwt_ext_pkg::match_len_t out_bwd_len;
	bwt_ext_pkg::bwt_idx_t   out_bwd_k;
	bwt_ext_pkg::bwt_idx_t   out_bwd_l;

	// accepted requests waiting for their response
	bwt_ext_pkg::bwt_idx_t   pend_k [$];
	bwt_ext_pkg::bwt_idx_t   pend_l [$];
	int                      pend_due [$];
	int                      cycle = 0;
	int                      out_count = 0;

	bwt_ext_top i_dut (
		.Clk_32UI        (clk),
		.rst_n_i         (rst_n),
		.load_valid_i    (load_valid),
		.load_ready_o    (load_ready),
		.load_seq_i      (load_seq),
		.mem_req_valid_o (mem_req_valid),
		.mem_req_ready_i (mem_req_ready),
		.mem_addr_k_o    (mem_addr_k),
		.mem_addr_l_o    (mem_addr_l),
		.mem_rsp_valid_i (mem_rsp_valid),
		.mem_cnt_k_i     (mem_cnt_k),
		.mem_cnt_l_i     (mem_cnt_l),
		.out_valid_o     (out_valid),
		.out_ready_i     (out_ready),
		.out_read_num_o  (out_read_num),
		.out_fwd_len_o   (out_fwd_len),
		.out_fwd_k_o     (out_fwd_k),
		.out_fwd_l_o     (out_fwd_l),
		.out_bwd_len_o   (out_bwd_len),
		.out_bwd_k_o     (out_bwd_k),
		.out_bwd_l_o     (out_bwd_l)
	);

	always #20 clk = ~clk;

	task automatic report_timeout(input string what);
		$display("TEST FAILED");
		$fatal(1, "timeout: %s", what);
	endtask

	// called on a falling edge, returns on the falling edge after the handshake
	task automatic load_read(input bwt_ext_pkg::read_seq_t seq);
		int waited;
		waited     = 0;
		load_valid = 1'b1;
		load_seq   = seq;
		while (!load_ready) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT)
				report_timeout("load_ready_o stayed low");
		end
		@(negedge clk);
		load_valid = 1'b0;
	endtask

	// ------------------------------------------------------------
	// memory model and output sink
	// ------------------------------------------------------------
	always @(negedge clk) begin
		cycle         = cycle + 1;
		mem_rsp_valid = 1'b0;
		if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
			mem_rsp_valid = 1'b1;
			for (int c = 0; c < 4; c++) begin
				mem_cnt_k[c] = pend_k[0] / 4;  // same count for every base
				mem_cnt_l[c] = pend_l[0] / 4;
			end
			void'(pend_k.pop_front());
			void'(pend_l.pop_front());
			void'(pend_due.pop_front());
		end
		mem_req_ready = ($urandom_range(3, 0) != 0);
		if (mem_req_valid && mem_req_ready) begin
			pend_k.push_back(mem_addr_k);
			pend_l.push_back(mem_addr_l);
			pend_due.push_back(cycle + $urandom_range(4, 1));
		end
		out_ready = ($urandom_range(1, 0) != 0);
		if (out_valid && out_ready)
			out_count++;  // taken on the next rising edge
	end

	// bound checker errors end the run
	always @(negedge clk) begin
		if (i_dut.i_asserts.fail_cnt != 0) begin
			$display("TEST FAILED");
			$fatal(1, "the bound checker flagged an error");
		end
	end

	initial begin
		bwt_ext_pkg::read_seq_t seq;
		int                     gap;
		int                     waited;
		void'($urandom(3127));
		clk        = 1'b0;
		rst_n      = 1'b0;
		load_valid = 1'b0;
		load_seq   = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		for (int n = 0; n < NUM_READS; n++) begin
			gap = $urandom_range(3, 0);
			repeat (gap) @(negedge clk);
			for (int i = 0; i < `BWT_READ_LEN; i++)
				seq[i] = bwt_ext_pkg::base_t'($urandom_range(3, 0));
			load_read(seq);
		end

		waited = 0;
		while (out_count < NUM_READS) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT)
				report_timeout("not all outputs arrived");
		end
		repeat (2) @(negedge clk);
		@(posedge clk);

		if (i_dut.i_asserts.fail_cnt == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "the bound checker flagged an error");
		end
	end

endmodule

// ==== bwt_ext_top.f ====
+incdir+source
source/bwt_ext_pkg.sv
source/read_buffer.sv
source/extension_engine.sv
source/extension_join.sv
source/bwt_ext_top.sv
tests/bwt_ext_asserts.sv
tests/tb_bwt_ext.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_bwt_ext \
	-f bwt_ext_top.f -Mdir obj_dir > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_bwt_ext +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
